//--- hdl/alu_op_pkg.sv
package alu_op_pkg;

    // Width of an operation code
    localparam int OP_W = 4;

    // Operation codes
    // Codes 14 and 15 are unused and execute as ADD
    typedef enum logic [OP_W-1:0] {
        ALUOP_ADD    = 4'd0,
        ALUOP_SUB    = 4'd1,
        ALUOP_AND    = 4'd2,
        ALUOP_OR     = 4'd3,
        ALUOP_XOR    = 4'd4,
        ALUOP_SLL    = 4'd5,
        ALUOP_SRL    = 4'd6,
        ALUOP_SRA    = 4'd7,
        ALUOP_SLT    = 4'd8,
        ALUOP_SLTU   = 4'd9,
        ALUOP_MUL    = 4'd10,
        ALUOP_MULH   = 4'd11,
        ALUOP_MULHSU = 4'd12,
        ALUOP_MULHU  = 4'd13
    } alu_op_t;

    // Multiply class spans a contiguous code range
    localparam alu_op_t MUL_FIRST = ALUOP_MUL;
    localparam alu_op_t MUL_LAST  = ALUOP_MULHU;

    // True for the four multi-cycle multiply codes
    function automatic logic is_mul(alu_op_t op);
        return (op >= MUL_FIRST) && (op <= MUL_LAST);
    endfunction

    // Only plain MUL keeps the low product half
    function automatic logic wants_low(alu_op_t op);
        return op == ALUOP_MUL;
    endfunction

endpackage

//--- hdl/alu_data_pkg.sv
package alu_data_pkg;

    // Operand and result width
    localparam int XLEN = 32;

    // Full multiplier product width
    localparam int PROD_W = 2 * XLEN;

    // Request into the execution unit (69 bits)
    typedef struct packed {
        // Strobe honoured only while the unit is not busy
        logic                  valid;
        alu_op_pkg::alu_op_t   op;
        logic [XLEN-1:0]       s1;
        logic [XLEN-1:0]       s2;
    } alu_req_t;

    // Response out of the execution unit (33 bits)
    typedef struct packed {
        // One-cycle pulse that qualifies the result
        logic                  done;
        logic [XLEN-1:0]       result;
    } alu_resp_t;

    // Build a response from its parts
    function automatic alu_resp_t make_resp(logic done, logic [XLEN-1:0] result);
        alu_resp_t r;
        r.done   = done;
        r.result = result;
        return r;
    endfunction

endpackage

//--- hdl/alu_logic.sv
`timescale 1ns/1ps

module alu_logic (
    input  alu_op_pkg::alu_op_t              op,
    input  logic [alu_data_pkg::XLEN-1:0]    a,
    input  logic [alu_data_pkg::XLEN-1:0]    b,
    output logic [alu_data_pkg::XLEN-1:0]    y
);

    localparam int XLEN    = alu_data_pkg::XLEN;
    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    diff;
    logic [XLEN-1:0]    sra_res;
    logic               lt_signed;
    logic               lt_unsigned;

    // Shift amount is the low five bits of b
    assign shamt = b[SHAMT_W-1:0];

    // Wraps on overflow like the hardware adder
    assign sum  = a + b;
    assign diff = a - b;

    // Arithmetic right shift keeps the sign of a
    assign sra_res = $unsigned($signed(a) >>> shamt);

    // Compares for SLT and SLTU
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_op_pkg::ALUOP_ADD: begin
                y = sum;
            end
            alu_op_pkg::ALUOP_SUB: begin
                y = diff;
            end
            alu_op_pkg::ALUOP_AND: begin
                y = a & b;
            end
            alu_op_pkg::ALUOP_OR: begin
                y = a | b;
            end
            alu_op_pkg::ALUOP_XOR: begin
                y = a ^ b;
            end
            alu_op_pkg::ALUOP_SLL: begin
                y = a << shamt;
            end
            alu_op_pkg::ALUOP_SRL: begin
                y = a >> shamt;
            end
            alu_op_pkg::ALUOP_SRA: begin
                y = sra_res;
            end
            alu_op_pkg::ALUOP_SLT: begin
                y = {{(XLEN-1){1'b0}}, lt_signed};
            end
            alu_op_pkg::ALUOP_SLTU: begin
                y = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            // Multiplies and the unused codes fall back to ADD
            default: begin
                y = sum;
            end
        endcase
    end

endmodule

//--- hdl/mul_seq.sv
`timescale 1ns/1ps

module mul_seq (
    input  logic                               I_clk,
    input  logic                               I_reset,
    input  logic                               start,
    input  alu_op_pkg::alu_op_t                op,
    input  logic [alu_data_pkg::XLEN-1:0]      s1,
    input  logic [alu_data_pkg::XLEN-1:0]      s2,
    output logic [alu_data_pkg::PROD_W-1:0]    product,
    output logic                               busy
);

    localparam int XLEN   = alu_data_pkg::XLEN;
    localparam int PROD_W = alu_data_pkg::PROD_W;

    logic              s1_signed;
    logic              s2_signed;
    logic              hi;
    logic              s1_ext;
    logic              s2_ext;

    logic              busy_q;
    logic [PROD_W-1:0] mcand;
    logic [PROD_W-1:0] mplier;
    logic [PROD_W-1:0] acc;
    logic [PROD_W-1:0] acc_next;
    logic              load;
    logic              step;

    // Signedness and result half from the op code
    always_comb begin
        s1_signed = 1'b0;
        s2_signed = 1'b0;
        hi        = 1'b1;
        case (op)
            alu_op_pkg::ALUOP_MUL: begin
                hi = 1'b0;
            end
            alu_op_pkg::ALUOP_MULH: begin
                s1_signed = 1'b1;
                s2_signed = 1'b1;
            end
            alu_op_pkg::ALUOP_MULHSU: begin
                s1_signed = 1'b1;
            end
            default: begin
                hi = 1'b1;
            end
        endcase
    end

    // Extension bits for the 64-bit operands
    assign s1_ext = s1_signed & s1[XLEN-1];
    // Low half only needs 32 iterations, so zero-extend the multiplier
    assign s2_ext = s2_signed & s2[XLEN-1] & hi;

    assign load = !busy_q && start;
    assign step = busy_q && (mplier != '0);

    // Add the shifted multiplicand when the low multiplier bit is set
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy_q <= 1'b0;
            acc    <= '0;
        end else if (load) begin
            busy_q <= 1'b1;
            acc    <= '0;
        end else if (step) begin
            acc <= acc_next;
        end else if (busy_q) begin
            // Multiplier exhausted, product is final
            busy_q <= 1'b0;
        end
    end

    // Operand shift registers
    always_ff @(posedge I_clk) begin
        if (load) begin
            mcand  <= {{XLEN{s1_ext}}, s1};
            mplier <= {{XLEN{s2_ext}}, s2};
        end else if (step) begin
            mcand  <= {mcand[PROD_W-2:0], 1'b0};
            mplier <= {1'b0, mplier[PROD_W-1:1]};
        end
    end

    assign product = acc;
    assign busy    = busy_q;

    // Issue logic must only start us for multiply codes
    a_start_is_mul: assert property (@(posedge I_clk) disable iff (I_reset)
        start |-> alu_op_pkg::is_mul(op));

    // A start while running would be silently dropped
    a_start_when_idle: assert property (@(posedge I_clk) disable iff (I_reset)
        start |-> !busy_q);

    // Worst case is a sign-extended 64-bit multiplier
    a_busy_bounded: assert property (@(posedge I_clk) disable iff (I_reset)
        $rose(busy_q) |-> ##[1:66] !busy_q);

endmodule

//--- hdl/alu_issue.sv
`timescale 1ns/1ps

module alu_issue (
    input  logic                               I_clk,
    input  logic                               I_reset,
    input  alu_data_pkg::alu_req_t             req,
    output alu_data_pkg::alu_resp_t            resp,
    output logic                               busy,
    output alu_op_pkg::alu_op_t                logic_op,
    output logic [alu_data_pkg::XLEN-1:0]      logic_a,
    output logic [alu_data_pkg::XLEN-1:0]      logic_b,
    input  logic [alu_data_pkg::XLEN-1:0]      logic_y,
    output logic                               mul_start,
    input  logic [alu_data_pkg::PROD_W-1:0]    mul_product,
    input  logic                               mul_busy
);

    localparam int XLEN = alu_data_pkg::XLEN;

    logic            accept;
    logic            req_is_mul;
    logic            pending_q;
    logic            mul_busy_q;
    logic            mul_fall;
    logic            mul_finish;
    logic            want_lo_q;
    logic            done_q;
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] mul_half;

    // Requests seen while busy are dropped, not queued
    assign accept     = req.valid && !pending_q;
    assign req_is_mul = alu_op_pkg::is_mul(req.op);

    // Single-cycle datapath sees the request directly
    assign logic_op = req.op;
    assign logic_a  = req.s1;
    assign logic_b  = req.s2;

    assign mul_start = accept && req_is_mul;

    // Falling edge of the multiplier busy
    assign mul_fall   = mul_busy_q && !mul_busy;
    assign mul_finish = pending_q && mul_fall;

    assign mul_half = want_lo_q ? mul_product[XLEN-1:0] : mul_product[2*XLEN-1:XLEN];

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            pending_q  <= 1'b0;
            mul_busy_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            mul_busy_q <= mul_busy;
            done_q     <= 1'b0;
            if (mul_finish) begin
                done_q    <= 1'b1;
                pending_q <= 1'b0;
            end else if (accept) begin
                if (req_is_mul) begin
                    pending_q <= 1'b1;
                end else begin
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Result and half select are payload
    always_ff @(posedge I_clk) begin
        if (mul_finish) begin
            result_q <= mul_half;
        end else if (accept && !req_is_mul) begin
            result_q <= logic_y;
        end
        if (mul_start) begin
            want_lo_q <= alu_op_pkg::wants_low(req.op);
        end
    end

    assign resp = alu_data_pkg::make_resp(done_q, result_q);
    assign busy = pending_q;

    // After a multiply's done, another done needs a fresh accept
    a_single_mul_done: assert property (@(posedge I_clk) disable iff (I_reset)
        (resp.done && $past(pending_q)) |=> (!resp.done || $past(accept)));

    // Busy already low when the result is presented
    a_busy_not_done: assert property (@(posedge I_clk) disable iff (I_reset)
        !(busy && resp.done));

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                       I_clk,
    input  logic                       I_reset,
    input  alu_data_pkg::alu_req_t     req,
    output alu_data_pkg::alu_resp_t    resp,
    output logic                       busy
);

    // Issue to single-cycle logic
    alu_op_pkg::alu_op_t                logic_op;
    logic [alu_data_pkg::XLEN-1:0]      logic_a;
    logic [alu_data_pkg::XLEN-1:0]      logic_b;
    logic [alu_data_pkg::XLEN-1:0]      logic_y;

    // Issue to multiplier
    logic                               mul_start;
    logic [alu_data_pkg::PROD_W-1:0]    mul_product;
    logic                               mul_busy;

    alu_issue i_alu_issue (
        .I_clk       (I_clk),
        .I_reset     (I_reset),
        .req         (req),
        .resp        (resp),
        .busy        (busy),
        .logic_op    (logic_op),
        .logic_a     (logic_a),
        .logic_b     (logic_b),
        .logic_y     (logic_y),
        .mul_start   (mul_start),
        .mul_product (mul_product),
        .mul_busy    (mul_busy)
    );

    alu_logic i_alu_logic (
        .op (logic_op),
        .a  (logic_a),
        .b  (logic_b),
        .y  (logic_y)
    );

    // Multiplier takes the same operands as the logic path
    mul_seq i_mul_seq (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .start   (mul_start),
        .op      (logic_op),
        .s1      (logic_a),
        .s2      (logic_b),
        .product (mul_product),
        .busy    (mul_busy)
    );

endmodule

//--- dv/tb_alu_unit.sv
`timescale 1ns/1ps

module tb_alu_unit;

    localparam int XLEN         = alu_data_pkg::XLEN;
    localparam int RESET_CYCLES = 16;
    localparam int SINGLE_N     = 20;
    localparam int MUL_CORNER_N = 14;
    localparam int LCG_PAIRS    = 40;
    localparam int MUL_LAT_MIN  = 3;
    localparam int MUL_LAT_MAX  = 67;
    localparam int MUL_LO_MAX   = 35;
    // Two extra entries for the back-pressure pair
    localparam int TOTAL_VECS   = SINGLE_N + MUL_CORNER_N + LCG_PAIRS + 2;
    localparam int WD_CYCLES    = TOTAL_VECS * 70 + 40;

    typedef struct packed {
        logic [alu_op_pkg::OP_W-1:0] op;
        logic [XLEN-1:0]             s1;
        logic [XLEN-1:0]             s2;
        logic [XLEN-1:0]             exp;
    } vec_t;

    logic                    I_clk = 1'b0;
    logic                    I_reset;
    alu_data_pkg::alu_req_t  req;
    alu_data_pkg::alu_resp_t resp;
    logic                    busy;

    logic [31:0] lcg_state;

    // Single-cycle corners with code 15 last
    vec_t single_vecs [SINGLE_N] = '{
        '{alu_op_pkg::ALUOP_ADD,  32'h7fff_ffff, 32'h0000_0001, 32'h0},
        '{alu_op_pkg::ALUOP_ADD,  32'hffff_ffff, 32'h0000_0001, 32'h0},
        '{alu_op_pkg::ALUOP_SUB,  32'h8000_0000, 32'h0000_0001, 32'h0},
        '{alu_op_pkg::ALUOP_SUB,  32'h0000_0000, 32'h0000_0001, 32'h0},
        '{alu_op_pkg::ALUOP_AND,  32'hf0f0_f0f0, 32'hff00_ff00, 32'h0},
        '{alu_op_pkg::ALUOP_OR,   32'hf0f0_f0f0, 32'h0f0f_0000, 32'h0},
        '{alu_op_pkg::ALUOP_XOR,  32'haaaa_aaaa, 32'hffff_0000, 32'h0},
        '{alu_op_pkg::ALUOP_SLL,  32'h1234_5678, 32'h0000_0000, 32'h0},
        '{alu_op_pkg::ALUOP_SLL,  32'h0000_0001, 32'h0000_001f, 32'h0},
        '{alu_op_pkg::ALUOP_SRL,  32'h8000_0000, 32'h0000_001f, 32'h0},
        '{alu_op_pkg::ALUOP_SRL,  32'h8765_4321, 32'h0000_0000, 32'h0},
        '{alu_op_pkg::ALUOP_SRA,  32'h8000_0000, 32'h0000_001f, 32'h0},
        '{alu_op_pkg::ALUOP_SRA,  32'hf000_0000, 32'h0000_0024, 32'h0},
        '{alu_op_pkg::ALUOP_SRA,  32'h7fff_fff0, 32'h0000_0004, 32'h0},
        '{alu_op_pkg::ALUOP_SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0},
        '{alu_op_pkg::ALUOP_SLT,  32'h0000_0001, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0},
        '{alu_op_pkg::ALUOP_SLTU, 32'h0000_0001, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_SLT,  32'h8000_0000, 32'h8000_0000, 32'h0},
        '{4'd15,                  32'h0000_0005, 32'hffff_fffb, 32'h0}
    };

    vec_t mul_vecs [MUL_CORNER_N] = '{
        '{alu_op_pkg::ALUOP_MUL,    32'h0000_0000, 32'h1234_5678, 32'h0},
        '{alu_op_pkg::ALUOP_MUL,    32'h0000_0001, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_MUL,    32'hffff_ffff, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_MUL,    32'h8000_0000, 32'h0000_0002, 32'h0},
        '{alu_op_pkg::ALUOP_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h0},
        '{alu_op_pkg::ALUOP_MULH,   32'h8000_0000, 32'h7fff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_MULH,   32'hffff_fffe, 32'h0000_0003, 32'h0},
        '{alu_op_pkg::ALUOP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_MULHSU, 32'h7fff_ffff, 32'h8000_0000, 32'h0},
        '{alu_op_pkg::ALUOP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'h0},
        '{alu_op_pkg::ALUOP_MULHU,  32'h8000_0000, 32'h8000_0000, 32'h0},
        '{alu_op_pkg::ALUOP_MULHU,  32'h0000_0000, 32'hffff_ffff, 32'h0}
    };

    alu_unit i_alu_unit (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .req     (req),
        .resp    (resp),
        .busy    (busy)
    );

    always #20 I_clk = ~I_clk;

    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            fail_run("a checked value was wrong");
        end
    endtask

    // Expected result straight from the operation definitions
    function automatic logic [31:0] model_result(input logic [3:0] op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [63:0] a_s;
        logic [63:0] a_u;
        logic [63:0] b_s;
        logic [63:0] b_u;
        logic [63:0] prod;
        logic [4:0]  sh;
        logic [31:0] y;
        a_s  = {{32{a[31]}}, a};
        a_u  = {32'h0, a};
        b_s  = {{32{b[31]}}, b};
        b_u  = {32'h0, b};
        sh   = b[4:0];
        prod = 64'h0;
        case (op)
            alu_op_pkg::ALUOP_SUB:  y = a - b;
            alu_op_pkg::ALUOP_AND:  y = a & b;
            alu_op_pkg::ALUOP_OR:   y = a | b;
            alu_op_pkg::ALUOP_XOR:  y = a ^ b;
            alu_op_pkg::ALUOP_SLL:  y = a << sh;
            alu_op_pkg::ALUOP_SRL:  y = a >> sh;
            // Fill the vacated top bits with the sign
            alu_op_pkg::ALUOP_SRA:  y = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            alu_op_pkg::ALUOP_SLT:  y = {31'h0, (a[31] != b[31]) ? a[31] : (a < b)};
            alu_op_pkg::ALUOP_SLTU: y = {31'h0, a < b};
            alu_op_pkg::ALUOP_MUL: begin
                prod = a_u * b_u;
                y    = prod[31:0];
            end
            alu_op_pkg::ALUOP_MULH: begin
                prod = a_s * b_s;
                y    = prod[63:32];
            end
            alu_op_pkg::ALUOP_MULHSU: begin
                prod = a_s * b_u;
                y    = prod[63:32];
            end
            alu_op_pkg::ALUOP_MULHU: begin
                prod = a_u * b_u;
                y    = prod[63:32];
            end
            // ADD and the unused codes
            default: y = a + b;
        endcase
        return y;
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic alu_data_pkg::alu_req_t make_req(input vec_t v);
        alu_data_pkg::alu_req_t r;
        r.valid = 1'b1;
        r.op    = alu_op_pkg::alu_op_t'(v.op);
        r.s1    = v.s1;
        r.s2    = v.s2;
        return r;
    endfunction

    // Count cycles from the accept edge up to the done cycle
    task automatic wait_done(output int lat);
        lat = 1;
        @(negedge I_clk);
        while (!resp.done) begin
            check_value("busy", 32'(busy), 32'd1);
            if (lat >= MUL_LAT_MAX) begin
                fail_run("multiply gave no done within 67 cycles");
            end
            lat++;
            @(negedge I_clk);
        end
        check_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic run_mul(input vec_t v);
        int lat;
        @(posedge I_clk);
        req <= make_req(v);
        @(negedge I_clk);
        check_value("busy", 32'(busy), 32'd0);
        @(posedge I_clk);
        req <= '0;
        wait_done(lat);
        check_value("resp.result", resp.result, v.exp);
        if (lat < MUL_LAT_MIN || lat > MUL_LAT_MAX) begin
            fail_run($sformatf("multiply latency of %0d cycles is out of range", lat));
        end
        if (v.op == alu_op_pkg::ALUOP_MUL && lat > MUL_LO_MAX) begin
            fail_run($sformatf("MUL took %0d cycles, more than 35", lat));
        end
        // Exactly one done per multiply
        @(negedge I_clk);
        check_value("resp.done", 32'(resp.done), 32'd0);
    endtask

    // ADD held valid while the multiply runs must wait for busy low
    task automatic run_backpressure(input vec_t m, input vec_t a);
        int lat;
        @(posedge I_clk);
        req <= make_req(m);
        @(posedge I_clk);
        req <= make_req(a);
        wait_done(lat);
        check_value("resp.result", resp.result, m.exp);
        @(posedge I_clk);
        req <= '0;
        @(negedge I_clk);
        check_value("resp.done", 32'(resp.done), 32'd1);
        check_value("resp.result", resp.result, a.exp);
        check_value("busy", 32'(busy), 32'd0);
        @(negedge I_clk);
        check_value("resp.done", 32'(resp.done), 32'd0);
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge I_clk);
        fail_run("run timed out waiting for done");
    end

    initial begin
        vec_t v;
        vec_t add_v;
        I_reset   = 1'b1;
        req       = '0;
        lcg_state = 32'd35;

        for (int i = 0; i < SINGLE_N; i++) begin
            single_vecs[i].exp = model_result(single_vecs[i].op, single_vecs[i].s1,
                                              single_vecs[i].s2);
        end
        for (int i = 0; i < MUL_CORNER_N; i++) begin
            mul_vecs[i].exp = model_result(mul_vecs[i].op, mul_vecs[i].s1, mul_vecs[i].s2);
        end

        // Reset state and the first cycle after release
        for (int c = 0; c < RESET_CYCLES - 1; c++) begin
            @(posedge I_clk);
            @(negedge I_clk);
            check_value("resp.done", 32'(resp.done), 32'd0);
            check_value("busy", 32'(busy), 32'd0);
        end
        @(posedge I_clk);
        I_reset <= 1'b0;
        @(negedge I_clk);
        check_value("resp.done", 32'(resp.done), 32'd0);
        check_value("busy", 32'(busy), 32'd0);

        // Result of entry i-1 shows while entry i is presented
        for (int i = 0; i < SINGLE_N; i++) begin
            @(posedge I_clk);
            req <= make_req(single_vecs[i]);
            @(negedge I_clk);
            check_value("busy", 32'(busy), 32'd0);
            if (i > 0) begin
                check_value("resp.done", 32'(resp.done), 32'd1);
                check_value("resp.result", resp.result, single_vecs[i-1].exp);
            end else begin
                check_value("resp.done", 32'(resp.done), 32'd0);
            end
        end
        @(posedge I_clk);
        req <= '0;
        @(negedge I_clk);
        check_value("resp.done", 32'(resp.done), 32'd1);
        check_value("resp.result", resp.result, single_vecs[SINGLE_N-1].exp);
        @(negedge I_clk);
        check_value("resp.done", 32'(resp.done), 32'd0);

        for (int i = 0; i < MUL_CORNER_N; i++) begin
            run_mul(mul_vecs[i]);
        end

        // Random pairs rotate through the four multiplies
        for (int i = 0; i < LCG_PAIRS; i++) begin
            lcg_state = lcg_step(lcg_state);
            v.s1      = lcg_state;
            lcg_state = lcg_step(lcg_state);
            v.s2      = lcg_state;
            v.op      = alu_op_pkg::ALUOP_MUL + 4'(i % 4);
            v.exp     = model_result(v.op, v.s1, v.s2);
            run_mul(v);
        end

        // Negative multiplier gives the longest MULH
        v.op      = alu_op_pkg::ALUOP_MULH;
        v.s1      = 32'h1234_5678;
        v.s2      = 32'hffff_fff0;
        v.exp     = model_result(v.op, v.s1, v.s2);
        add_v.op  = alu_op_pkg::ALUOP_ADD;
        add_v.s1  = 32'h0000_1000;
        add_v.s2  = 32'h0000_0234;
        add_v.exp = model_result(add_v.op, add_v.s1, add_v.s2);
        run_backpressure(v, add_v);

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- src.f
hdl/alu_op_pkg.sv
hdl/alu_data_pkg.sv
hdl/alu_logic.sv
hdl/mul_seq.sv
hdl/alu_issue.sv
hdl/alu_unit.sv
dv/tb_alu_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the alu_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_alu_unit -Mdir obj_dir -f src.f

./obj_dir/Vtb_alu_unit 2>&1 | tee "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
